/* Makefile */
TOOL     := verilator
TOP      := tb_icache
FILELIST := src.f
FLAGS    := --binary --timing --assert -j 0
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* icache_ctrl.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_fetch_req,
    input  icache_pkg::fetch_addr_t i_fetch_addr,
    input  logic                    i_flush,
    input  logic                    i_mem_valid,
    input  icache_pkg::line_t       i_mem_line,
    input  icache_pkg::tag_t        i_tag_0,
    input  icache_pkg::tag_t        i_tag_1,
    input  logic                    i_valid_0,
    input  logic                    i_valid_1,
    input  icache_pkg::line_t       i_line_0,
    input  icache_pkg::line_t       i_line_1,
    input  logic                    i_victim_way,
    output logic                    o_fetch_valid,
    output icache_pkg::inst_t       o_fetch_data,
    output logic                    o_mem_req,
    output icache_pkg::fetch_addr_t o_mem_addr,
    output icache_pkg::index_t      o_rd_index,
    output icache_pkg::index_t      o_wr_index,
    output icache_pkg::tag_t        o_tag_wdata,
    output logic                    o_fill_0,
    output logic                    o_fill_1,
    output logic                    o_flush,
    output logic                    o_hit_en,
    output logic                    o_hit_way,
    output logic                    o_fill_en,
    output logic                    o_fill_way
);
    import icache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    fetch_addr_t addr_q;
    tag_t        req_tag;
    index_t      req_index;
    logic        hit_0;
    logic        hit_1;
    logic        hit;
    logic        refill_wr;
    line_t       hit_line;

    assign req_tag   = addr_q[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
    assign req_index = addr_q[`ICACHE_INDEX_MSB:`ICACHE_INDEX_LSB];

    // flush wins over a fetch in the same cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_fetch_req && !i_flush) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP:  state_d = COMPARE;
            COMPARE: state_d = hit ? IDLE : REFILL;
            REFILL: begin
                // line is written now, lookup again to serve it
                if (i_mem_valid) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && i_fetch_req) begin
            addr_q <= i_fetch_addr;
        end
    end

    // tag compare on the array outputs
    assign hit_0    = i_valid_0 && (i_tag_0 == req_tag);
    assign hit_1    = i_valid_1 && (i_tag_1 == req_tag);
    assign hit      = hit_0 || hit_1;
    assign hit_line = hit_1 ? i_line_1 : i_line_0;

    assign refill_wr = (state_q == REFILL) && i_mem_valid;

    // both arrays are indexed by the held request
    assign o_rd_index  = req_index;
    assign o_wr_index  = req_index;
    assign o_tag_wdata = req_tag;
    assign o_fill_0    = refill_wr && !i_victim_way;
    assign o_fill_1    = refill_wr && i_victim_way;
    assign o_fill_en   = refill_wr;
    assign o_fill_way  = i_victim_way;
    assign o_hit_en    = (state_q == COMPARE) && hit;
    assign o_hit_way   = hit_1;

    // valid and lru bits clear at the edge that samples the flush
    assign o_flush     = (state_q == IDLE) && i_flush;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_fetch_valid <= 1'b0;
            o_mem_req     <= 1'b0;
        end else begin
            o_fetch_valid <= (state_q == COMPARE) && hit;
            o_mem_req     <= (state_q == COMPARE) && !hit;
        end
    end

    // bit 2 set picks the upper word
    always_ff @(posedge clk) begin
        if (state_q == COMPARE && hit) begin
            o_fetch_data <= addr_q[`ICACHE_WORD_BIT] ? hit_line[63:32] : hit_line[31:0];
        end
        if (state_q == COMPARE && !hit) begin
            o_mem_addr <= {addr_q[`ICACHE_ADDR_W-1:`ICACHE_INDEX_LSB],
                           {`ICACHE_INDEX_LSB{1'b0}}};
        end
    end

    a_req_resp_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_mem_req && o_fetch_valid))
        else $error("memory request and fetch response together");

    a_req_in_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_fetch_req || i_flush) |-> state_q == IDLE)
        else $error("fetch or flush while the cache is busy");

    a_single_way_hit: assert property (@(posedge clk) disable iff (!i_rst_n)
        state_q == COMPARE |-> !(hit_0 && hit_1))
        else $error("line resident in both ways");

endmodule

/* icache_data_ram.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_ram (
    input  logic               clk,
    input  icache_pkg::index_t i_rd_index,
    input  icache_pkg::index_t i_wr_index,
    input  logic               i_wr_en,
    input  icache_pkg::line_t  i_wr_line,
    output icache_pkg::line_t  o_line
);
    import icache_pkg::*;

    line_t line_mem [`ICACHE_SETS];

    // refill writes a whole line in one cycle
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            line_mem[i_wr_index] <= i_wr_line;
        end
    end

    // read data lands one cycle after the index
    always_ff @(posedge clk) begin
        o_line <= line_mem[i_rd_index];
    end

endmodule

/* icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address width
`define ICACHE_ADDR_W 32

// two ways of 64 sets, one 64-bit line per entry
`define ICACHE_SETS 64

// set index field
`define ICACHE_INDEX_LSB 3
`define ICACHE_INDEX_MSB 8

// tag runs from here up to the top address bit
`define ICACHE_TAG_LSB 9

// picks the upper or lower instruction of a line
`define ICACHE_WORD_BIT 2

`endif

/* icache_lru.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_lru (
    input  logic               clk,
    input  logic               i_rst_n,
    input  icache_pkg::index_t i_index,
    input  logic               i_valid_0,
    input  logic               i_valid_1,
    input  logic               i_hit_en,
    input  logic               i_hit_way,
    input  logic               i_fill_en,
    input  logic               i_fill_way,
    input  logic               i_flush,
    output logic               o_victim_way
);
    // one bit per set, names the least recently used way
    logic [`ICACHE_SETS-1:0] lru_q;

    // empty ways first, way 0 before way 1
    always_comb begin
        if (!i_valid_0) begin
            o_victim_way = 1'b0;
        end else if (!i_valid_1) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = lru_q[i_index];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lru_q <= '0;
        end else if (i_flush) begin
            lru_q <= '0;
        end else if (i_hit_en) begin
            lru_q[i_index] <= ~i_hit_way;
        end else if (i_fill_en) begin
            lru_q[i_index] <= ~i_fill_way;
        end
    end

    a_hit_fill_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_hit_en && i_fill_en))
        else $error("lru sees hit and fill in one cycle");

endmodule

/* icache_pkg.sv */
`include "icache_defines.svh"

package icache_pkg;

    // full fetch address
    typedef logic [`ICACHE_ADDR_W-1:0] fetch_addr_t;

    // tag field above the set index
    typedef logic [`ICACHE_ADDR_W-`ICACHE_TAG_LSB-1:0] tag_t;

    // set number
    typedef logic [`ICACHE_INDEX_MSB-`ICACHE_INDEX_LSB:0] index_t;

    // one line holds two instructions
    typedef logic [63:0] line_t;
    typedef logic [31:0] inst_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        REFILL
    } ctrl_state_e;

endpackage

/* icache_tag_ram.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tag_ram (
    input  logic               clk,
    input  logic               i_rst_n,
    input  icache_pkg::index_t i_rd_index,
    input  icache_pkg::index_t i_wr_index,
    input  logic               i_wr_en,
    input  icache_pkg::tag_t   i_wr_tag,
    input  logic               i_flush,
    output icache_pkg::tag_t   o_tag,
    output logic               o_valid
);
    import icache_pkg::*;

    tag_t                    tag_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_q;

    // tag storage, registered read
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index] <= i_wr_tag;
        end
        o_tag <= tag_mem[i_rd_index];
    end

    // flush drops every line at once
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (i_flush) begin
            valid_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= valid_q[i_rd_index];
        end
    end

endmodule

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_fetch_req,
    input  icache_pkg::fetch_addr_t i_fetch_addr,
    input  logic                    i_flush,
    input  logic                    i_mem_valid,
    input  icache_pkg::line_t       i_mem_line,
    output logic                    o_fetch_valid,
    output icache_pkg::inst_t       o_fetch_data,
    output logic                    o_mem_req,
    output icache_pkg::fetch_addr_t o_mem_addr
);
    import icache_pkg::*;

    index_t rd_index;
    index_t wr_index;
    tag_t   tag_wdata;
    tag_t   tag_0;
    tag_t   tag_1;
    line_t  line_0;
    line_t  line_1;
    logic   valid_0;
    logic   valid_1;
    logic   fill_0;
    logic   fill_1;
    logic   flush;
    logic   hit_en;
    logic   hit_way;
    logic   fill_en;
    logic   fill_way;
    logic   victim_way;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .i_flush      (i_flush),
        .i_mem_valid  (i_mem_valid),
        .i_mem_line   (i_mem_line),
        .i_tag_0      (tag_0),
        .i_tag_1      (tag_1),
        .i_valid_0    (valid_0),
        .i_valid_1    (valid_1),
        .i_line_0     (line_0),
        .i_line_1     (line_1),
        .i_victim_way (victim_way),
        .o_fetch_valid(o_fetch_valid),
        .o_fetch_data (o_fetch_data),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .o_rd_index   (rd_index),
        .o_wr_index   (wr_index),
        .o_tag_wdata  (tag_wdata),
        .o_fill_0     (fill_0),
        .o_fill_1     (fill_1),
        .o_flush      (flush),
        .o_hit_en     (hit_en),
        .o_hit_way    (hit_way),
        .o_fill_en    (fill_en),
        .o_fill_way   (fill_way)
    );

    // way 0
    icache_tag_ram u_tag_0 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_wr_en    (fill_0),
        .i_wr_tag   (tag_wdata),
        .i_flush    (flush),
        .o_tag      (tag_0),
        .o_valid    (valid_0)
    );

    icache_data_ram u_data_0 (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_wr_en    (fill_0),
        .i_wr_line  (i_mem_line),
        .o_line     (line_0)
    );

    // way 1
    icache_tag_ram u_tag_1 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_wr_en    (fill_1),
        .i_wr_tag   (tag_wdata),
        .i_flush    (flush),
        .o_tag      (tag_1),
        .o_valid    (valid_1)
    );

    icache_data_ram u_data_1 (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_wr_en    (fill_1),
        .i_wr_line  (i_mem_line),
        .o_line     (line_1)
    );

    icache_lru u_lru (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_index      (wr_index),
        .i_valid_0    (valid_0),
        .i_valid_1    (valid_1),
        .i_hit_en     (hit_en),
        .i_hit_way    (hit_way),
        .i_fill_en    (fill_en),
        .i_fill_way   (fill_way),
        .i_flush      (flush),
        .o_victim_way (victim_way)
    );

endmodule

/* src.f */
+incdir+.
icache_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_lru.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int NUM_ENTRIES  = 24;
    localparam int RESET_CYCLES = 16;
    localparam int RESP_LIMIT   = 20;

    typedef enum logic {OP_FETCH, OP_FLUSH} op_e;

    logic        clk;
    logic        i_rst_n;
    logic        i_fetch_req;
    fetch_addr_t i_fetch_addr;
    logic        i_flush;
    logic        i_mem_valid;
    line_t       i_mem_line;
    logic        o_fetch_valid;
    inst_t       o_fetch_data;
    logic        o_mem_req;
    fetch_addr_t o_mem_addr;

    op_e         op_tab   [NUM_ENTRIES];
    fetch_addr_t addr_tab [NUM_ENTRIES];
    bit          miss_tab [NUM_ENTRIES];

    int          errors;
    int          checks;
    int          mem_req_count;
    fetch_addr_t last_mem_addr;

    icache_top uut (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .i_flush      (i_flush),
        .i_mem_valid  (i_mem_valid),
        .i_mem_line   (i_mem_line),
        .o_fetch_valid(o_fetch_valid),
        .o_fetch_data (o_fetch_data),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // line contents of the memory model
    function automatic line_t model_line(input fetch_addr_t line_addr);
        return {line_addr ^ 32'h1357_9bdf, line_addr + 32'h0000_0100};
    endfunction

    task automatic set_entry(input int idx, input op_e op, input fetch_addr_t addr,
                             input bit miss);
        op_tab[idx]   = op;
        addr_tab[idx] = addr;
        miss_tab[idx] = miss;
    endtask

    // set 5 holds tags A 0x1028, B 0x3028, C 0x5028; D 0x0a40 sits in set 8
    task automatic load_table();
        set_entry(0,  OP_FETCH, 32'h0000_1028, 1'b1);
        set_entry(1,  OP_FETCH, 32'h0000_1028, 1'b0);
        set_entry(2,  OP_FETCH, 32'h0000_102c, 1'b0);
        set_entry(3,  OP_FETCH, 32'h0000_3028, 1'b1);
        set_entry(4,  OP_FETCH, 32'h0000_3028, 1'b0);
        set_entry(5,  OP_FETCH, 32'h0000_1028, 1'b0);
        set_entry(6,  OP_FETCH, 32'h0000_5028, 1'b1);
        set_entry(7,  OP_FETCH, 32'h0000_102c, 1'b0);
        set_entry(8,  OP_FETCH, 32'h0000_3028, 1'b1);
        set_entry(9,  OP_FETCH, 32'h0000_1028, 1'b0);
        set_entry(10, OP_FETCH, 32'h0000_502c, 1'b1);
        set_entry(11, OP_FETCH, 32'h0000_1028, 1'b0);
        set_entry(12, OP_FETCH, 32'h0000_3028, 1'b1);
        set_entry(13, OP_FETCH, 32'h0000_0a40, 1'b1);
        set_entry(14, OP_FETCH, 32'h0000_0a44, 1'b0);
        set_entry(15, OP_FETCH, 32'hffff_fffc, 1'b1);
        set_entry(16, OP_FETCH, 32'hffff_fff8, 1'b0);
        set_entry(17, OP_FLUSH, 32'h0000_0000, 1'b0);
        set_entry(18, OP_FETCH, 32'h0000_1028, 1'b1);
        set_entry(19, OP_FETCH, 32'h0000_302c, 1'b1);
        set_entry(20, OP_FETCH, 32'h0000_0a40, 1'b1);
        set_entry(21, OP_FETCH, 32'h0000_1028, 1'b0);
        set_entry(22, OP_FETCH, 32'h0000_302c, 1'b0);
        set_entry(23, OP_FETCH, 32'h0000_0a44, 1'b0);
    endtask

    task automatic run_fetch(input int idx, input fetch_addr_t addr, input bit exp_miss);
        int          req_before;
        int          cycles;
        fetch_addr_t line_addr;
        line_t       exp_line;
        inst_t       exp_data;
        req_before = mem_req_count;
        line_addr  = {addr[31:3], 3'b000};
        exp_line   = model_line(line_addr);
        exp_data   = addr[2] ? exp_line[63:32] : exp_line[31:0];
        @(negedge clk);
        // a flush from the previous entry ends here
        i_flush      = 1'b0;
        i_fetch_req  = 1'b1;
        i_fetch_addr = addr;
        @(negedge clk);
        i_fetch_req  = 1'b0;
        i_fetch_addr = '0;
        cycles = 1;
        while (!o_fetch_valid && cycles < RESP_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        if (!o_fetch_valid) begin
            $display("entry %0d: no fetch response for address %h", idx, addr);
            errors++;
        end else begin
            checks++;
            if (o_fetch_data != exp_data) begin
                $display("MISMATCH at %0t: entry %0d addr %h data %h expected %h",
                         $time, idx, addr, o_fetch_data, exp_data);
                errors++;
            end
            // sampled one negedge after the response edge
            checks++;
            if (!exp_miss && cycles - 1 != 2) begin
                $display("MISMATCH at %0t: entry %0d hit latency %0d expected 2",
                         $time, idx, cycles - 1);
                errors++;
            end
        end
        checks++;
        if (mem_req_count - req_before != (exp_miss ? 1 : 0)) begin
            $display("MISMATCH at %0t: entry %0d saw %0d memory requests expected %0d",
                     $time, idx, mem_req_count - req_before, exp_miss ? 1 : 0);
            errors++;
        end else if (exp_miss && last_mem_addr != line_addr) begin
            $display("MISMATCH at %0t: entry %0d memory address %h expected %h",
                     $time, idx, last_mem_addr, line_addr);
            errors++;
        end
    endtask

    // the next fetch follows in the very next cycle
    task automatic apply_flush();
        @(negedge clk);
        i_flush = 1'b1;
    endtask

    // every cycle with a memory request strobe counts once
    initial begin
        mem_req_count = 0;
        last_mem_addr = '0;
        forever begin
            @(negedge clk);
            if (o_mem_req) begin
                mem_req_count++;
                last_mem_addr = o_mem_addr;
            end
        end
    end

    // memory model, one outstanding line at a time
    initial begin
        int unsigned seed_ret;
        int unsigned delay;
        i_mem_valid   = 1'b0;
        i_mem_line    = '0;
        seed_ret      = $urandom(32'hf993_3b58);
        forever begin
            @(negedge clk);
            if (o_mem_req) begin
                delay = 1 + ($urandom % 6);
                repeat (delay - 1) @(negedge clk);
                i_mem_valid = 1'b1;
                i_mem_line  = model_line({o_mem_addr[31:3], 3'b000});
                @(negedge clk);
                i_mem_valid = 1'b0;
                i_mem_line  = '0;
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_ENTRIES * 20) @(posedge clk);
        $display("watchdog expired before the stimulus table finished");
        $display("checks: %0d  errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        errors       = 0;
        checks       = 0;
        i_rst_n      = 1'b0;
        i_fetch_req  = 1'b0;
        i_fetch_addr = '0;
        i_flush      = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (op_tab[i] == OP_FLUSH) begin
                apply_flush();
            end else begin
                run_fetch(i, addr_tab[i], miss_tab[i]);
            end
        end
        repeat (4) @(negedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
